// ==== rob_cfg_pkg.sv ====
/*
 * reorder buffer configuration
 * field widths and the derived types shared by every block
 */
package rob_cfg_pkg;

	localparam int pc_width          = 64;
	localparam int arn_width         = 5;
	localparam int prf_size          = 64;
	localparam int prn_width         = $clog2(prf_size);
	localparam int default_rob_depth = 8;	// entries per thread

	// thread bit on top, entry number in the low bits
	localparam int rob_idx_width = $clog2(default_rob_depth) + 1;

	typedef logic [pc_width-1:0]      pc_t;
	typedef logic [arn_width-1:0]     arn_t;
	typedef logic [prn_width-1:0]     prn_t;
	typedef logic [rob_idx_width-1:0] rob_idx_t;

endpackage

// ==== rob_types_pkg.sv ====
/*
 * reorder buffer structs
 * entry payload, functional unit completion and commit slot
 */
package rob_types_pkg;

	typedef struct packed {
		rob_cfg_pkg::pc_t  pc;
		rob_cfg_pkg::pc_t  target_pc;	// valid once a mispredict is reported
		logic              is_branch;
		logic              mispredict;
		rob_cfg_pkg::arn_t arn_dest;
		rob_cfg_pkg::prn_t prn_dest;
		logic              done;
	} rob_entry_t;

	typedef struct packed {
		logic                  valid;
		rob_cfg_pkg::rob_idx_t rob_idx;
		logic                  mispredict;
		rob_cfg_pkg::pc_t      target_pc;
	} rob_complete_t;

	typedef struct packed {
		logic              valid;
		logic              thread1;	// high when the entry came from thread 1
		rob_cfg_pkg::pc_t  pc;
		rob_cfg_pkg::pc_t  target_pc;
		logic              is_branch;
		logic              mispredict;
		rob_cfg_pkg::arn_t arn_dest;
		rob_cfg_pkg::prn_t prn_dest;
	} rob_commit_t;

endpackage

// ==== rob_ifs.sv ====
/*
 * reorder buffer interfaces
 * dispatch_if carries a bundle into one thread queue
 * retire_if carries head state out and the retire decision back
 */
`timescale 1ns/1ps

interface dispatch_if #(
	parameter int rob_depth = rob_cfg_pkg::default_rob_depth
);
	import rob_types_pkg::*;

	logic                         load1;
	logic                         load2;	// only meaningful with load1
	rob_entry_t                   slot1;
	rob_entry_t                   slot2;
	logic [$clog2(rob_depth)-1:0] tail;	// next free entry
	logic                         full;

	modport steer (
		output load1, load2, slot1, slot2,
		input  tail, full
	);

	modport queue (
		input  load1, load2, slot1, slot2,
		output tail, full
	);

endinterface

interface retire_if;
	import rob_types_pkg::*;

	rob_entry_t head_entry;
	rob_entry_t next_entry;
	logic       head_ready;	// head occupied and done
	logic       next_ready;	// same for the entry after the head
	logic [1:0] retire_count;	// 0, 1 or 2
	logic       squash;

	modport queue (
		output head_entry, next_entry, head_ready, next_ready,
		input  retire_count, squash
	);

	modport select (
		input  head_entry, next_entry, head_ready, next_ready,
		output retire_count, squash
	);

endinterface

// ==== rob_thread_queue.sv ====
/*
 * per-thread reorder queue
 * circular entry store with head and tail pointers, completion marking,
 * in-order retire and squash of everything younger than the head
 */
`timescale 1ns/1ps

module rob_thread_queue #(
	parameter int rob_depth = rob_cfg_pkg::default_rob_depth,
	parameter bit thread_id = 1'b0
)(
	input  logic                        clock,
	input  logic                        reset,
	dispatch_if.queue                   dispatch,
	input  rob_types_pkg::rob_complete_t complete1,
	input  rob_types_pkg::rob_complete_t complete2,
	retire_if.queue                     retire
);
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;

	localparam int entry_width = $clog2(rob_depth);

	typedef logic [entry_width-1:0] ptr_t;

	rob_entry_t entries [rob_depth];

	ptr_t head;
	ptr_t tail;
	ptr_t head_plus1;
	ptr_t tail_plus1;
	ptr_t head_next;
	ptr_t tail_next;
	ptr_t comp1_entry;
	ptr_t comp2_entry;
	logic comp1_hit;
	logic comp2_hit;
	logic [1:0] load_count;
	logic head_occupied;
	logic next_occupied;

	assign head_plus1 = head + 1'b1;
	assign tail_plus1 = tail + 1'b1;

	// one entry is always left free so full and empty differ
	assign dispatch.full = (tail_plus1 == head);
	assign dispatch.tail = tail;

	assign head_occupied = (head != tail);
	assign next_occupied = head_occupied && (head_plus1 != tail);

	assign retire.head_entry = entries[head];
	assign retire.next_entry = entries[head_plus1];
	assign retire.head_ready = head_occupied && entries[head].done;
	assign retire.next_ready = next_occupied && entries[head_plus1].done;

	// completions address this queue only when the thread bit matches
	assign comp1_hit   = complete1.valid && (complete1.rob_idx[rob_idx_width-1] == thread_id);
	assign comp2_hit   = complete2.valid && (complete2.rob_idx[rob_idx_width-1] == thread_id);
	assign comp1_entry = complete1.rob_idx[entry_width-1:0];
	assign comp2_entry = complete2.rob_idx[entry_width-1:0];

	always_comb
	begin
		load_count = 2'd0;
		if (dispatch.load1)
		begin
			load_count = dispatch.load2 ? 2'd2 : 2'd1;
		end

		head_next = head + ptr_t'(retire.retire_count);

		// squash drops every entry younger than the retired branch
		if (retire.squash)
		begin
			tail_next = head_next;
		end
		else
		begin
			tail_next = tail + ptr_t'(load_count);
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
		end
		else
		begin
			head <= head_next;
			tail <= tail_next;
		end
	end

	// entry storage
	always_ff @(posedge clock)
	begin
		if (dispatch.load1)
		begin
			entries[tail] <= dispatch.slot1;
		end
		if (dispatch.load1 && dispatch.load2)
		begin
			entries[tail_plus1] <= dispatch.slot2;
		end
		if (comp1_hit)
		begin
			entries[comp1_entry].done       <= 1'b1;
			entries[comp1_entry].mispredict <= complete1.mispredict;
			entries[comp1_entry].target_pc  <= complete1.target_pc;
		end
		if (comp2_hit)
		begin
			entries[comp2_entry].done       <= 1'b1;
			entries[comp2_entry].mispredict <= complete2.mispredict;
			entries[comp2_entry].target_pc  <= complete2.target_pc;
		end
	end

endmodule

// ==== dispatch_steer.sv ====
/*
 * dispatch steering
 * sends a one or two instruction bundle to its thread queue
 * and returns the assigned ROB indices in the same cycle
 */
`timescale 1ns/1ps

module dispatch_steer #(
	parameter int rob_depth = rob_cfg_pkg::default_rob_depth
)(
	input  logic                      is_thread1,
	input  logic                      inst1_load,
	input  logic                      inst2_load,
	input  rob_types_pkg::rob_entry_t inst1,
	input  rob_types_pkg::rob_entry_t inst2,
	input  logic                      squash_any,
	dispatch_if.steer                 t1_dispatch,
	dispatch_if.steer                 t2_dispatch,
	output rob_cfg_pkg::rob_idx_t     inst1_rob_idx,
	output rob_cfg_pkg::rob_idx_t     inst2_rob_idx
);
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;

	localparam int entry_width = $clog2(rob_depth);

	logic accept1;
	logic accept2;
	logic [entry_width-1:0] tail_sel;
	logic [entry_width-1:0] tail_sel_plus1;
	rob_entry_t slot1;
	rob_entry_t slot2;

	assign tail_sel       = is_thread1 ? t1_dispatch.tail : t2_dispatch.tail;
	assign tail_sel_plus1 = tail_sel + 1'b1;	// wraps with the queue

	// slot 2 alone, a full target or a squash cycle dispatches nothing
	assign accept1 = inst1_load && !squash_any &&
		!(is_thread1 ? t1_dispatch.full : t2_dispatch.full);
	assign accept2 = accept1 && inst2_load;

	always_comb
	begin
		slot1            = inst1;
		slot1.done       = 1'b0;
		slot1.mispredict = 1'b0;
		slot2            = inst2;
		slot2.done       = 1'b0;
		slot2.mispredict = 1'b0;

		inst1_rob_idx = '0;
		inst2_rob_idx = '0;
		if (accept1)
		begin
			inst1_rob_idx[entry_width-1:0]   = tail_sel;
			inst1_rob_idx[rob_idx_width-1]   = ~is_thread1;
		end
		if (accept2)
		begin
			inst2_rob_idx[entry_width-1:0]   = tail_sel_plus1;
			inst2_rob_idx[rob_idx_width-1]   = ~is_thread1;
		end
	end

	assign t1_dispatch.load1 = accept1 && is_thread1;
	assign t1_dispatch.load2 = accept2 && is_thread1;
	assign t1_dispatch.slot1 = slot1;
	assign t1_dispatch.slot2 = slot2;
	assign t2_dispatch.load1 = accept1 && !is_thread1;
	assign t2_dispatch.load2 = accept2 && !is_thread1;
	assign t2_dispatch.slot1 = slot1;
	assign t2_dispatch.slot2 = slot2;

endmodule

// ==== commit_select.sv ====
/*
 * commit selection
 * retires up to two ready head entries per cycle, thread 1 first,
 * and flags a squash when a mispredicted branch retires
 */
`timescale 1ns/1ps

module commit_select (
	retire_if.select                    t1_retire,
	retire_if.select                    t2_retire,
	output rob_types_pkg::rob_commit_t  commit1,
	output rob_types_pkg::rob_commit_t  commit2,
	output logic                        squash_any
);
	import rob_types_pkg::*;

	logic t1_squash;
	logic t2_squash;

	function automatic logic is_mispredict(input rob_entry_t e);
		return e.is_branch && e.mispredict;
	endfunction

	function automatic rob_commit_t make_commit(input rob_entry_t e, input logic thread1);
		rob_commit_t c;
		c.valid      = 1'b1;
		c.thread1    = thread1;
		c.pc         = e.pc;
		c.target_pc  = e.target_pc;
		c.is_branch  = e.is_branch;
		c.mispredict = e.mispredict;
		c.arn_dest   = e.arn_dest;
		c.prn_dest   = e.prn_dest;
		return c;
	endfunction

	always_comb
	begin
		commit1                = '0;
		commit2                = '0;
		t1_retire.retire_count = 2'd0;
		t2_retire.retire_count = 2'd0;

		if (t1_retire.head_ready)
		begin
			commit1 = make_commit(t1_retire.head_entry, 1'b1);
			// a mispredicted head stops its own thread after one entry
			if (t1_retire.next_ready && !is_mispredict(t1_retire.head_entry))
			begin
				commit2                = make_commit(t1_retire.next_entry, 1'b1);
				t1_retire.retire_count = 2'd2;
			end
			else if (t2_retire.head_ready)
			begin
				commit2                = make_commit(t2_retire.head_entry, 1'b0);
				t1_retire.retire_count = 2'd1;
				t2_retire.retire_count = 2'd1;
			end
			else
			begin
				t1_retire.retire_count = 2'd1;
			end
		end
		else if (t2_retire.head_ready)
		begin
			commit1 = make_commit(t2_retire.head_entry, 1'b0);
			if (t2_retire.next_ready && !is_mispredict(t2_retire.head_entry))
			begin
				commit2                = make_commit(t2_retire.next_entry, 1'b0);
				t2_retire.retire_count = 2'd2;
			end
			else
			begin
				t2_retire.retire_count = 2'd1;
			end
		end
	end

	// squash per thread from either commit slot
	assign t1_squash = (commit1.valid && commit1.thread1 && commit1.is_branch && commit1.mispredict) ||
		(commit2.valid && commit2.thread1 && commit2.is_branch && commit2.mispredict);
	assign t2_squash = (commit1.valid && !commit1.thread1 && commit1.is_branch && commit1.mispredict) ||
		(commit2.valid && !commit2.thread1 && commit2.is_branch && commit2.mispredict);

	assign t1_retire.squash = t1_squash;
	assign t2_retire.squash = t2_squash;
	assign squash_any       = t1_squash || t2_squash;

endmodule

// ==== smt_rob.sv ====
/*
 * two-thread reorder buffer
 * dispatch steering, one circular queue per thread and commit selection
 */
`timescale 1ns/1ps

module smt_rob #(
	parameter int rob_depth = rob_cfg_pkg::default_rob_depth
)(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  is_thread1,	// bundle belongs to thread 1
	input  logic                  inst1_load,
	input  rob_cfg_pkg::pc_t      inst1_pc,
	input  rob_cfg_pkg::arn_t     inst1_arn_dest,
	input  rob_cfg_pkg::prn_t     inst1_prn_dest,
	input  logic                  inst1_is_branch,
	input  logic                  inst2_load,
	input  rob_cfg_pkg::pc_t      inst2_pc,
	input  rob_cfg_pkg::arn_t     inst2_arn_dest,
	input  rob_cfg_pkg::prn_t     inst2_prn_dest,
	input  logic                  inst2_is_branch,
	input  logic                  fu1_valid,
	input  rob_cfg_pkg::rob_idx_t fu1_rob_idx,
	input  logic                  fu1_mispredict,
	input  rob_cfg_pkg::pc_t      fu1_target_pc,
	input  logic                  fu2_valid,
	input  rob_cfg_pkg::rob_idx_t fu2_rob_idx,
	input  logic                  fu2_mispredict,
	input  rob_cfg_pkg::pc_t      fu2_target_pc,
	output rob_cfg_pkg::rob_idx_t inst1_rob_idx,
	output rob_cfg_pkg::rob_idx_t inst2_rob_idx,
	output logic                  commit1_valid,
	output logic                  commit1_is_thread1,
	output rob_cfg_pkg::pc_t      commit1_pc,
	output rob_cfg_pkg::pc_t      commit1_target_pc,
	output logic                  commit1_is_branch,
	output logic                  commit1_mispredict,
	output rob_cfg_pkg::arn_t     commit1_arn_dest,
	output rob_cfg_pkg::prn_t     commit1_prn_dest,
	output logic                  commit2_valid,
	output logic                  commit2_is_thread1,
	output rob_cfg_pkg::pc_t      commit2_pc,
	output rob_cfg_pkg::pc_t      commit2_target_pc,
	output logic                  commit2_is_branch,
	output logic                  commit2_mispredict,
	output rob_cfg_pkg::arn_t     commit2_arn_dest,
	output rob_cfg_pkg::prn_t     commit2_prn_dest,
	output logic                  t1_full,
	output logic                  t2_full
);
	import rob_types_pkg::*;

	rob_entry_t    inst1;
	rob_entry_t    inst2;
	rob_complete_t complete1;
	rob_complete_t complete2;
	rob_commit_t   commit1;
	rob_commit_t   commit2;
	logic          squash_any;

	dispatch_if #(.rob_depth(rob_depth)) t1_dispatch ();
	dispatch_if #(.rob_depth(rob_depth)) t2_dispatch ();
	retire_if t1_retire ();
	retire_if t2_retire ();

	// target and status fields are filled in at completion
	assign inst1 = '{pc: inst1_pc, target_pc: '0, is_branch: inst1_is_branch, mispredict: 1'b0,
		arn_dest: inst1_arn_dest, prn_dest: inst1_prn_dest, done: 1'b0};
	assign inst2 = '{pc: inst2_pc, target_pc: '0, is_branch: inst2_is_branch, mispredict: 1'b0,
		arn_dest: inst2_arn_dest, prn_dest: inst2_prn_dest, done: 1'b0};

	assign complete1 = '{valid: fu1_valid, rob_idx: fu1_rob_idx, mispredict: fu1_mispredict,
		target_pc: fu1_target_pc};
	assign complete2 = '{valid: fu2_valid, rob_idx: fu2_rob_idx, mispredict: fu2_mispredict,
		target_pc: fu2_target_pc};

	dispatch_steer #(.rob_depth(rob_depth)) steer_i (
		.is_thread1    (is_thread1),
		.inst1_load    (inst1_load),
		.inst2_load    (inst2_load),
		.inst1         (inst1),
		.inst2         (inst2),
		.squash_any    (squash_any),
		.t1_dispatch   (t1_dispatch.steer),
		.t2_dispatch   (t2_dispatch.steer),
		.inst1_rob_idx (inst1_rob_idx),
		.inst2_rob_idx (inst2_rob_idx)
	);

	rob_thread_queue #(.rob_depth(rob_depth), .thread_id(1'b0)) t1_queue_i (
		.clock     (clock),
		.reset     (reset),
		.dispatch  (t1_dispatch.queue),
		.complete1 (complete1),
		.complete2 (complete2),
		.retire    (t1_retire.queue)
	);

	rob_thread_queue #(.rob_depth(rob_depth), .thread_id(1'b1)) t2_queue_i (
		.clock     (clock),
		.reset     (reset),
		.dispatch  (t2_dispatch.queue),
		.complete1 (complete1),
		.complete2 (complete2),
		.retire    (t2_retire.queue)
	);

	commit_select select_i (
		.t1_retire  (t1_retire.select),
		.t2_retire  (t2_retire.select),
		.commit1    (commit1),
		.commit2    (commit2),
		.squash_any (squash_any)
	);

	assign t1_full = t1_dispatch.full;
	assign t2_full = t2_dispatch.full;

	assign commit1_valid      = commit1.valid;
	assign commit1_is_thread1 = commit1.thread1;
	assign commit1_pc         = commit1.pc;
	assign commit1_target_pc  = commit1.target_pc;
	assign commit1_is_branch  = commit1.is_branch;
	assign commit1_mispredict = commit1.mispredict;
	assign commit1_arn_dest   = commit1.arn_dest;
	assign commit1_prn_dest   = commit1.prn_dest;
	assign commit2_valid      = commit2.valid;
	assign commit2_is_thread1 = commit2.thread1;
	assign commit2_pc         = commit2.pc;
	assign commit2_target_pc  = commit2.target_pc;
	assign commit2_is_branch  = commit2.is_branch;
	assign commit2_mispredict = commit2.mispredict;
	assign commit2_arn_dest   = commit2.arn_dest;
	assign commit2_prn_dest   = commit2.prn_dest;

endmodule

// ==== tb_smt_rob.sv ====
/*
 * testbench for the two-thread reorder buffer
 * random dispatch, completion and mispredicts against a per-thread model
 */
`timescale 1ns/1ps

module tb_smt_rob;
	import rob_cfg_pkg::*;

	localparam int depth = 8;

	logic clock, reset, is_thread1, inst1_load, inst2_load;
	logic inst1_is_branch, inst2_is_branch, fu1_valid, fu2_valid, fu1_mispredict, fu2_mispredict;
	pc_t inst1_pc, inst2_pc, fu1_target_pc, fu2_target_pc;
	arn_t inst1_arn_dest, inst2_arn_dest;
	prn_t inst1_prn_dest, inst2_prn_dest;
	rob_idx_t fu1_rob_idx, fu2_rob_idx, inst1_rob_idx, inst2_rob_idx;
	logic commit1_valid, commit1_is_thread1, commit1_is_branch, commit1_mispredict;
	logic commit2_valid, commit2_is_thread1, commit2_is_branch, commit2_mispredict;
	pc_t commit1_pc, commit1_target_pc, commit2_pc, commit2_target_pc;
	arn_t commit1_arn_dest, commit2_arn_dest;
	prn_t commit1_prn_dest, commit2_prn_dest;
	logic t1_full, t2_full;

	// reference model per thread with index 0 for thread 1
	pc_t m_pc [2][depth];
	pc_t m_target [2][depth];
	bit m_done [2][depth];
	bit m_misp [2][depth];	// mispredicted branch
	bit m_branch [2][depth];
	arn_t m_arn [2][depth];
	prn_t m_prn [2][depth];
	int m_head [2];
	int m_tail [2];
	bit full_pre [2];
	bit squash_now;
	int errors = 0;
	int checks = 0;
	int commits = 0;
	integer seed = 32'hec7;

	smt_rob #(.rob_depth(8)) smt_rob_i (.*);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic int count(input int t);
		return (m_tail[t] - m_head[t] + depth) % depth;
	endfunction

	function automatic bit ready(input int t, input int k);
		return (count(t) > k) && m_done[t][(m_head[t] + k) % depth];
	endfunction

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			$display("error: %s", what);
		end
	endtask

	// one commit slot against the head of its thread
	task automatic retire_slot(input string slot, input logic thr1, input pc_t pc,
		input pc_t target, input logic misp, input logic branch, input arn_t arn,
		input prn_t prn);
		int t;
		int e;
		t = thr1 ? 0 : 1;
		if (count(t) == 0)
		begin
			check_true(1'b0, "commit from a thread with no live entries");
		end
		else
		begin
			e = m_head[t];
			check_value({slot, "_pc"}, pc, m_pc[t][e]);
			check_value({slot, "_is_branch"}, 64'(branch), 64'(m_branch[t][e]));
			check_value({slot, "_arn_dest"}, 64'(arn), 64'(m_arn[t][e]));
			check_value({slot, "_prn_dest"}, 64'(prn), 64'(m_prn[t][e]));
			check_value({slot, "_mispredict"}, 64'(misp), 64'(m_misp[t][e]));
			if (m_misp[t][e])
			begin
				check_value({slot, "_target_pc"}, target, m_target[t][e]);
			end
			m_head[t] = (e + 1) % depth;
			commits++;
			if (m_misp[t][e])
			begin
				m_tail[t] = m_head[t];	// younger entries are gone
				squash_now = 1'b1;
			end
		end
	endtask

	// commit outputs come from registered state only at the falling edge
	task automatic check_commits();
		bit r1h;
		bit r1n;
		bit r2h;
		bit r2n;
		bit exp1_valid;
		bit exp2_valid;
		bit exp2_thr1;
		full_pre[0] = ((m_tail[0] + 1) % depth) == m_head[0];
		full_pre[1] = ((m_tail[1] + 1) % depth) == m_head[1];
		check_value("t1_full", 64'(t1_full), 64'(full_pre[0]));
		check_value("t2_full", 64'(t2_full), 64'(full_pre[1]));
		squash_now = 1'b0;
		r1h = ready(0, 0);
		r1n = ready(0, 1) && !m_misp[0][m_head[0]];
		r2h = ready(1, 0);
		r2n = ready(1, 1) && !m_misp[1][m_head[1]];
		exp1_valid = r1h || r2h;
		exp2_valid = r1h ? (r1n || r2h) : (r2h && r2n);
		exp2_thr1  = r1h && r1n;
		check_value("commit1_valid", 64'(commit1_valid), 64'(exp1_valid));
		check_value("commit2_valid", 64'(commit2_valid), 64'(exp2_valid));
		if (exp1_valid)
		begin
			check_value("commit1_is_thread1", 64'(commit1_is_thread1), 64'(r1h));
			retire_slot("commit1", r1h, commit1_pc, commit1_target_pc, commit1_mispredict,
				commit1_is_branch, commit1_arn_dest, commit1_prn_dest);
		end
		if (exp2_valid)
		begin
			check_value("commit2_is_thread1", 64'(commit2_is_thread1), 64'(exp2_thr1));
			retire_slot("commit2", exp2_thr1, commit2_pc, commit2_target_pc,
				commit2_mispredict, commit2_is_branch, commit2_arn_dest, commit2_prn_dest);
		end
	endtask

	task automatic clear_inputs();
		{is_thread1, inst1_load, inst2_load, inst1_is_branch, inst2_is_branch} = '0;
		{fu1_valid, fu2_valid, fu1_mispredict, fu2_mispredict} = '0;
		{inst1_pc, inst2_pc, fu1_target_pc, fu2_target_pc} = '0;
		{inst1_arn_dest, inst2_arn_dest, inst1_prn_dest, inst2_prn_dest} = '0;
		{fu1_rob_idx, fu2_rob_idx} = '0;
	endtask

	// one cycle of stimulus with completions picked at random among pending entries
	task automatic drive_cycle(input bit thr1, input bit l1, input bit l2, input int ncomp,
		input bit allow_misp);
		int pending[$];
		int k;
		int t;
		int e;
		bit accept;
		@(negedge clock);
		check_commits();
		clear_inputs();
		for (int i = 0; i < 2; i++)
		begin
			for (int j = 0; j < count(i); j++)
			begin
				if (!m_done[i][(m_head[i] + j) % depth])
				begin
					pending.push_back(i * depth + (m_head[i] + j) % depth);
				end
			end
		end
		for (int n = 0; n < ncomp && pending.size() > 0; n++)
		begin
			k = {$random(seed)} % pending.size();
			t = pending[k] / depth;
			e = pending[k] % depth;
			pending.delete(k);
			m_done[t][e] = 1'b1;
			m_misp[t][e] = allow_misp && m_branch[t][e] && ({$random(seed)} % 3 == 0);
			m_target[t][e] = {$random(seed), $random(seed)};
			if (n == 0)
			begin
				{fu1_valid, fu1_rob_idx} = {1'b1, t[0], e[2:0]};
				{fu1_mispredict, fu1_target_pc} = {m_misp[t][e], m_target[t][e]};
			end
			else
			begin
				{fu2_valid, fu2_rob_idx} = {1'b1, t[0], e[2:0]};
				{fu2_mispredict, fu2_target_pc} = {m_misp[t][e], m_target[t][e]};
			end
		end
		t = thr1 ? 0 : 1;
		is_thread1 = thr1;
		inst1_load = l1;
		inst2_load = l2 && count(t) <= depth - 3;	// never past the last free entry
		inst1_pc = {$random(seed), $random(seed)};
		inst2_pc = {$random(seed), $random(seed)};
		inst1_is_branch = ($random(seed) & 3) == 0;
		inst2_is_branch = ($random(seed) & 3) == 0;
		inst1_arn_dest = arn_t'($random(seed));
		inst2_arn_dest = arn_t'($random(seed));
		inst1_prn_dest = prn_t'($random(seed));
		inst2_prn_dest = prn_t'($random(seed));
		#1;
		accept = l1 && !full_pre[t] && !squash_now;
		if (accept)
		begin
			check_value("inst1_rob_idx", 64'(inst1_rob_idx), 64'({t[0], m_tail[t][2:0]}));
			m_pc[t][m_tail[t]] = inst1_pc;
			m_branch[t][m_tail[t]] = inst1_is_branch;
			m_arn[t][m_tail[t]] = inst1_arn_dest;
			m_prn[t][m_tail[t]] = inst1_prn_dest;
			{m_done[t][m_tail[t]], m_misp[t][m_tail[t]]} = 2'b00;
			m_tail[t] = (m_tail[t] + 1) % depth;
		end
		else
		begin
			check_value("inst1_rob_idx", 64'(inst1_rob_idx), 64'd0);
		end
		if (accept && inst2_load)
		begin
			check_value("inst2_rob_idx", 64'(inst2_rob_idx), 64'({t[0], m_tail[t][2:0]}));
			m_pc[t][m_tail[t]] = inst2_pc;
			m_branch[t][m_tail[t]] = inst2_is_branch;
			m_arn[t][m_tail[t]] = inst2_arn_dest;
			m_prn[t][m_tail[t]] = inst2_prn_dest;
			{m_done[t][m_tail[t]], m_misp[t][m_tail[t]]} = 2'b00;
			m_tail[t] = (m_tail[t] + 1) % depth;
		end
		else
		begin
			check_value("inst2_rob_idx", 64'(inst2_rob_idx), 64'd0);
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((count(0) != 0 || count(1) != 0) && n < 200)
		begin
			drive_cycle(1'b1, 1'b0, 1'b0, 2, 1'b0);
			n++;
		end
		if (count(0) != 0 || count(1) != 0)
		begin
			$display("timeout: the buffer did not drain within 200 cycles");
			$display("TESTS FAILED");
			$finish;
		end
	endtask

	initial
	begin
		clear_inputs();
		m_head = '{0, 0};
		m_tail = '{0, 0};
		reset = 1'b1;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_value("commit1_valid", 64'(commit1_valid), 64'd0);
		check_value("commit2_valid", 64'(commit2_valid), 64'd0);
		check_value("t1_full", 64'(t1_full), 64'd0);
		check_value("t2_full", 64'(t2_full), 64'd0);
		for (int i = 0; i < 400; i++)
		begin
			drive_cycle(($random(seed) & 1) != 0, ($random(seed) & 3) != 0,
				($random(seed) & 1) != 0, {$random(seed)} % 3, 1'b1);
		end
		drain();
		// fill thread 1 to its limit then try once more
		repeat (depth - 1) drive_cycle(1'b1, 1'b1, 1'b0, 0, 1'b0);
		drive_cycle(1'b1, 1'b1, 1'b1, 0, 1'b0);
		check_value("t1_full", 64'(t1_full), 64'd1);
		check_value("inst1_rob_idx", 64'(inst1_rob_idx), 64'd0);
		drain();
		drive_cycle(1'b0, 1'b0, 1'b0, 0, 1'b0);
		$display("errors %0d, checks %0d, commits %0d", errors, checks, commits);
		if (errors == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
rob_cfg_pkg.sv
rob_types_pkg.sv
rob_ifs.sv
rob_thread_queue.sv
dispatch_steer.sv
commit_select.sv
smt_rob.sv
tb_smt_rob.sv

// ==== Makefile ====
# Verilator build for the two-thread reorder buffer

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= tb_smt_rob
RTL_TOP   ?= smt_rob
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
